//--- design/geodesic_pkg.sv
package geodesic_pkg;

    typedef logic [6:0]  coord_x_t;
    typedef logic [5:0]  coord_y_t;
    typedef logic [12:0] pixel_addr_t;
    typedef logic [15:0] color_t;
    typedef logic [10:0] count_t;
    typedef logic [1:0]  round_t;
    typedef logic [3:0]  lfsr_t;

    typedef enum logic [1:0] {
        DRAWING,
        ANSWERED,
        JUDGED
    } verdict_state_t;

    // Display and disc
    localparam int       SCREEN_W    = 96;
    localparam int       SCREEN_H    = 64;
    localparam int       PIXEL_COUNT = SCREEN_W * SCREEN_H;
    localparam coord_x_t CENTER_X    = 7'd48;
    localparam coord_y_t CENTER_Y    = 6'd32;
    localparam int       DISC_RADIUS = 32;

    // Fixed rings and random circle offsets
    localparam int       RING_MAJOR        = 31;
    localparam int       RING_MINOR        = 12;
    localparam coord_y_t RANDOM_MINOR_BASE = 6'd17;
    localparam coord_y_t POINT_HIGH_BASE   = 6'd5;
    localparam coord_y_t POINT_LOW_BASE    = 6'd42;
    localparam coord_y_t POINT_MIN_ROW     = 6'd4;

    // Scoring
    localparam count_t MIN_OVERLAP = 11'd8;
    localparam count_t MAX_OFF     = 11'd128;
    localparam round_t LAST_ROUND  = 2'd3;

    // RGB565
    localparam color_t BLACK  = 16'h0000;
    localparam color_t BLUE   = 16'h001F;
    localparam color_t WHITE  = 16'hFFFF;
    localparam color_t RED    = 16'hF800;
    localparam color_t ORANGE = 16'hFDA0;
    localparam color_t PURPLE = 16'hF81E;
    localparam color_t GREEN  = 16'h07E0;
    localparam color_t YELLOW = 16'hFFE0;

endpackage

//--- design/round_control.sv
module round_control
    import geodesic_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     new_round,
    input  logic     mouse_l,
    input  count_t   overlap_count,
    input  count_t   off_count,
    output round_t   round,
    output coord_y_t minor_radius,
    output coord_y_t point_high,
    output coord_y_t point_low,
    output logic     side,
    output logic     answered,
    output logic     correct,
    output logic     incorrect
);

    lfsr_t          lfsr_q;
    verdict_state_t state;
    logic           pass;

    // Round counter and LFSR
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round  <= round_t'(1);
            lfsr_q <= '0;
        end else if (new_round) begin
            lfsr_q <= {lfsr_q[2:0], ~(lfsr_q[2] ^ lfsr_q[3])};
            if (round != LAST_ROUND) begin
                round <= round + round_t'(1);
            end
        end
    end

    // Random great circle and its end rows
    assign minor_radius = coord_y_t'(lfsr_q) + RANDOM_MINOR_BASE;
    assign point_high   = coord_y_t'(lfsr_q) + POINT_HIGH_BASE;
    assign point_low    = coord_y_t'(lfsr_q) + POINT_LOW_BASE;
    assign side         = lfsr_q[0];

    assign pass = (overlap_count >= MIN_OVERLAP) && (off_count < MAX_OFF);

    //////////////////////////////////////////////////
    // Verdict FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= DRAWING;
            correct   <= 1'b0;
            incorrect <= 1'b0;
        end else if (new_round) begin
            state     <= DRAWING;
            correct   <= 1'b0;
            incorrect <= 1'b0;
        end else begin
            case (state)
                DRAWING: begin
                    if (mouse_l) begin
                        state <= ANSWERED;
                    end
                end
                ANSWERED, JUDGED: begin
                    if (mouse_l) begin
                        state <= ANSWERED;
                    end else begin
                        // Judged again on every released cycle
                        state     <= JUDGED;
                        correct   <= pass;
                        incorrect <= !pass;
                    end
                end
                default: begin
                    state <= DRAWING;
                end
            endcase
        end
    end

    assign answered = (state != DRAWING);

endmodule

//--- design/pixel_geometry.sv
module pixel_geometry
    import geodesic_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        pixel_valid,
    input  coord_x_t    pixel_x,
    input  coord_y_t    pixel_y,
    input  coord_x_t    mouse_x,
    input  coord_y_t    mouse_y,
    input  logic        mouse_l,
    input  coord_y_t    minor_radius,
    input  coord_y_t    point_high,
    input  coord_y_t    point_low,
    input  logic        side,
    input  logic        answered,
    output logic        stage_valid,
    output pixel_addr_t stage_addr,
    output logic        in_disc,
    output logic        on_ring,
    output logic        on_point,
    output logic        point_halo,
    output logic        on_arc,
    output logic        target,
    output logic        in_footprint,
    output logic        in_cursor
);

    coord_x_t    dx_abs;
    coord_y_t    dy_abs;
    logic [31:0] dx2;
    logic [31:0] dy2;
    coord_y_t    dist_high;
    coord_y_t    dist_low;
    coord_x_t    foot_dx;
    coord_y_t    foot_dy;
    coord_x_t    curs_dx;
    coord_y_t    curs_dy;
    logic        random_ring;
    logic        on_side;
    logic        marker_row;
    logic        disc_next;
    logic        ring_next;
    logic        target_next;
    pixel_addr_t addr_next;

    // Band test between ellipses (a-1, b-band) and (a+1, b+band)
    function automatic logic on_ellipse(input logic [31:0] sq_x, input logic [31:0] sq_y,
                                        input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] band);
        logic [31:0] ab2;
        logic [31:0] outer;
        logic [31:0] inner;
        ab2   = a * a * b * b;
        outer = (a + 1) * (a + 1) * sq_x + (b + band) * (b + band) * sq_y;
        inner = (a - 1) * (a - 1) * sq_x + (b - band) * (b - band) * sq_y;
        return (outer >= ab2) && (inner <= ab2);
    endfunction

    assign dx_abs = (pixel_x >= CENTER_X) ? pixel_x - CENTER_X : CENTER_X - pixel_x;
    assign dy_abs = (pixel_y >= CENTER_Y) ? pixel_y - CENTER_Y : CENTER_Y - pixel_y;
    assign dx2    = 32'(dx_abs) * 32'(dx_abs);
    assign dy2    = 32'(dy_abs) * 32'(dy_abs);

    assign disc_next = (dx2 + dy2) < 32'(DISC_RADIUS * DISC_RADIUS);
    assign ring_next = on_ellipse(dx2, dy2, RING_MAJOR, RING_MINOR, 1)
                    || on_ellipse(dx2, dy2, RING_MINOR, RING_MAJOR, 1);

    // Random great circle on the chosen half
    assign random_ring = on_ellipse(dx2, dy2, RING_MAJOR, 32'(minor_radius), 2);
    assign on_side     = side ? (pixel_x > CENTER_X) : (pixel_x < CENTER_X);
    assign target_next = random_ring && on_side
                      && (pixel_y >= point_high) && (pixel_y <= point_low);

    // End point markers
    assign dist_high  = (pixel_y >= point_high) ? pixel_y - point_high : point_high - pixel_y;
    assign dist_low   = (pixel_y >= point_low) ? pixel_y - point_low : point_low - pixel_y;
    assign marker_row = random_ring && on_side && (pixel_y > POINT_MIN_ROW);

    // Mouse offsets wrap, so one compare covers both neighbours
    assign foot_dx = pixel_x - mouse_x;
    assign foot_dy = pixel_y - mouse_y;
    assign curs_dx = pixel_x - mouse_x + coord_x_t'(1);
    assign curs_dy = pixel_y - mouse_y + coord_y_t'(1);

    assign addr_next = pixel_addr_t'(pixel_y) * pixel_addr_t'(SCREEN_W) + pixel_addr_t'(pixel_x);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= pixel_valid;
        end
    end

    always_ff @(posedge clock) begin
        stage_addr   <= addr_next;
        in_disc      <= disc_next;
        on_ring      <= ring_next;
        target       <= target_next;
        on_arc       <= target_next && answered && !mouse_l;
        on_point     <= marker_row && ((dist_high <= 6'd1) || (dist_low <= 6'd1));
        point_halo   <= marker_row && ((dist_high == 6'd2) || (dist_low == 6'd2));
        in_footprint <= mouse_l && disc_next && (foot_dx <= 7'd1) && (foot_dy <= 6'd1);
        in_cursor    <= (curs_dx <= 7'd2) && (curs_dy <= 6'd2);
    end

endmodule

//--- design/pixel_scorer.sv
module pixel_scorer
    import geodesic_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  round_t      round,
    input  logic        new_round,
    input  logic        stage_valid,
    input  pixel_addr_t stage_addr,
    input  logic        in_disc,
    input  logic        on_ring,
    input  logic        on_point,
    input  logic        point_halo,
    input  logic        on_arc,
    input  logic        target,
    input  logic        in_footprint,
    input  logic        in_cursor,
    output logic        color_valid,
    output color_t      color,
    output count_t      drawn_count,
    output count_t      overlap_count,
    output count_t      off_count
);

    round_t tag_mem [PIXEL_COUNT];
    round_t stored_tag;
    logic   draw_new;
    color_t round_color;
    color_t color_next;

    // Tag 0 marks a pixel never drawn
    initial begin
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            tag_mem[i] = '0;
        end
    end

    assign stored_tag = tag_mem[stage_addr];

    // Each pixel is classified once per round as it is first drawn
    assign draw_new = stage_valid && in_footprint && !new_round && (stored_tag != round);

    always_ff @(posedge clock) begin
        if (draw_new) begin
            tag_mem[stage_addr] <= round;
        end
    end

    //////////////////////////////////////////////////
    // Score counters
    //////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            drawn_count   <= '0;
            overlap_count <= '0;
            off_count     <= '0;
        end else if (new_round) begin
            drawn_count   <= '0;
            overlap_count <= '0;
            off_count     <= '0;
        end else if (draw_new) begin
            drawn_count <= drawn_count + count_t'(1);
            if (target) begin
                overlap_count <= overlap_count + count_t'(1);
            end else begin
                off_count <= off_count + count_t'(1);
            end
        end
    end

    always_comb begin
        case (round)
            2'd2:    round_color = GREEN;
            2'd3:    round_color = YELLOW;
            default: round_color = PURPLE;
        endcase
    end

    // Later layers win
    always_comb begin
        color_next = BLACK;
        if (in_disc) color_next = BLUE;
        if (on_ring) color_next = WHITE;
        if ((stored_tag == round) || draw_new) color_next = round_color;
        if (on_point || on_arc) color_next = RED;
        if (point_halo) color_next = BLACK;
        if (in_cursor) color_next = ORANGE;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            color_valid <= 1'b0;
        end else begin
            color_valid <= stage_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            color <= color_next;
        end
    end

endmodule

//--- design/geodesic_game.sv
module geodesic_game
    import geodesic_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     pixel_valid,
    input  coord_x_t pixel_x,
    input  coord_y_t pixel_y,
    input  coord_x_t mouse_x,
    input  coord_y_t mouse_y,
    input  logic     mouse_l,
    input  logic     new_round,
    output logic     color_valid,
    output color_t   color,
    output count_t   drawn_count,
    output count_t   overlap_count,
    output count_t   off_count,
    output round_t   round,
    output logic     correct,
    output logic     incorrect
);

    coord_y_t    minor_radius;
    coord_y_t    point_high;
    coord_y_t    point_low;
    logic        side;
    logic        answered;

    // Stage one bundle
    logic        stage_valid;
    pixel_addr_t stage_addr;
    logic        in_disc;
    logic        on_ring;
    logic        on_point;
    logic        point_halo;
    logic        on_arc;
    logic        target;
    logic        in_footprint;
    logic        in_cursor;

    round_control u_round_control (
        .clock         (clock),
        .reset         (reset),
        .new_round     (new_round),
        .mouse_l       (mouse_l),
        .overlap_count (overlap_count),
        .off_count     (off_count),
        .round         (round),
        .minor_radius  (minor_radius),
        .point_high    (point_high),
        .point_low     (point_low),
        .side          (side),
        .answered      (answered),
        .correct       (correct),
        .incorrect     (incorrect)
    );

    pixel_geometry u_pixel_geometry (
        .clock        (clock),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .mouse_x      (mouse_x),
        .mouse_y      (mouse_y),
        .mouse_l      (mouse_l),
        .minor_radius (minor_radius),
        .point_high   (point_high),
        .point_low    (point_low),
        .side         (side),
        .answered     (answered),
        .stage_valid  (stage_valid),
        .stage_addr   (stage_addr),
        .in_disc      (in_disc),
        .on_ring      (on_ring),
        .on_point     (on_point),
        .point_halo   (point_halo),
        .on_arc       (on_arc),
        .target       (target),
        .in_footprint (in_footprint),
        .in_cursor    (in_cursor)
    );

    pixel_scorer u_pixel_scorer (
        .clock         (clock),
        .reset         (reset),
        .round         (round),
        .new_round     (new_round),
        .stage_valid   (stage_valid),
        .stage_addr    (stage_addr),
        .in_disc       (in_disc),
        .on_ring       (on_ring),
        .on_point      (on_point),
        .point_halo    (point_halo),
        .on_arc        (on_arc),
        .target        (target),
        .in_footprint  (in_footprint),
        .in_cursor     (in_cursor),
        .color_valid   (color_valid),
        .color         (color),
        .drawn_count   (drawn_count),
        .overlap_count (overlap_count),
        .off_count     (off_count)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clock
);

    // Half of a 40 unit period
    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

endmodule

//--- tests/geodesic_game_properties.sv
module geodesic_game_properties
    import geodesic_pkg::*;
(
    input logic   clock,
    input logic   reset,
    input logic   pixel_valid,
    input logic   color_valid,
    input logic   new_round,
    input count_t drawn_count,
    input count_t overlap_count,
    input count_t off_count,
    input logic   correct,
    input logic   incorrect
);

    verdict_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(correct && incorrect))
        else $error("correct and incorrect are high together");

    // Two register stages from scan to colour
    pipeline_latency: assert property (@(posedge clock) disable iff (reset)
        color_valid == $past(pixel_valid, 2))
        else $error("color_valid does not follow pixel_valid by two cycles");

    counts_cleared: assert property (@(posedge clock) disable iff (reset)
        new_round |=> (drawn_count == '0) && (overlap_count == '0) && (off_count == '0))
        else $error("score counts not cleared after new_round");

endmodule

//--- tests/geodesic_game_tb.sv
module geodesic_game_tb
    import geodesic_pkg::*;
();

    logic     clock;
    logic     reset;
    logic     pixel_valid;
    coord_x_t pixel_x;
    coord_y_t pixel_y;
    coord_x_t mouse_x;
    coord_y_t mouse_y;
    logic     mouse_l;
    logic     new_round;
    logic     color_valid;
    color_t   color;
    count_t   drawn_count;
    count_t   overlap_count;
    count_t   off_count;
    round_t   round;
    logic     correct;
    logic     incorrect;

    int       checks;
    int       mismatches;
    int       failures;
    logic     aborted;
    round_t   model_round;
    lfsr_t    model_lfsr;

    tb_clock u_clock (
        .clock (clock)
    );

    geodesic_game u_dut (
        .clock         (clock),
        .reset         (reset),
        .pixel_valid   (pixel_valid),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_l       (mouse_l),
        .new_round     (new_round),
        .color_valid   (color_valid),
        .color         (color),
        .drawn_count   (drawn_count),
        .overlap_count (overlap_count),
        .off_count     (off_count),
        .round         (round),
        .correct       (correct),
        .incorrect     (incorrect)
    );

    bind geodesic_game geodesic_game_properties u_properties (
        .clock         (clock),
        .reset         (reset),
        .pixel_valid   (pixel_valid),
        .color_valid   (color_valid),
        .new_round     (new_round),
        .drawn_count   (drawn_count),
        .overlap_count (overlap_count),
        .off_count     (off_count),
        .correct       (correct),
        .incorrect     (incorrect)
    );

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_color(input string name, input color_t expected, input color_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_round(input string name, input round_t expected, input round_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_row(input string name, input coord_y_t expected, input coord_y_t actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // XNOR feedback from bits 2 and 3
    function automatic lfsr_t next_lfsr(input lfsr_t state);
        return {state[2:0], ~(state[2] ^ state[3])};
    endfunction

    task automatic check_round_rows();
        check_round("round", model_round, round);
        check_row("point_high", coord_y_t'(model_lfsr) + POINT_HIGH_BASE, u_dut.point_high);
        check_row("point_low", coord_y_t'(model_lfsr) + POINT_LOW_BASE, u_dut.point_low);
    endtask

    //////////////////////////////////////////////////
    // Trace commands
    //////////////////////////////////////////////////
    task automatic set_mouse(input coord_x_t x, input coord_y_t y, input logic button);
        @(negedge clock);
        mouse_x = x;
        mouse_y = y;
        mouse_l = button;
    endtask

    task automatic scan_pixel(input coord_x_t x, input coord_y_t y, input color_t expected);
        int waited;
        @(negedge clock);
        pixel_valid = 1'b1;
        pixel_x     = x;
        pixel_y     = y;
        @(negedge clock);
        pixel_valid = 1'b0;
        waited      = 0;
        while (!color_valid && waited < 10) begin
            @(negedge clock);
            waited++;
        end
        if (!color_valid) begin
            failures++;
            aborted = 1'b1;
            $display("no color_valid within 10 cycles for pixel (%0d,%0d)", x, y);
        end else begin
            check_color($sformatf("color at (%0d,%0d)", x, y), expected, color);
        end
    endtask

    task automatic check_score(input count_t drawn, input count_t overlap, input count_t off,
                               input int verdict);
        @(negedge clock);
        check_count("drawn_count", drawn, drawn_count);
        check_count("overlap_count", overlap, overlap_count);
        check_count("off_count", off, off_count);
        check_flag("correct", verdict == 1, correct);
        check_flag("incorrect", verdict == 2, incorrect);
        check_round("round", model_round, round);
    endtask

    task automatic pulse_new_round();
        @(negedge clock);
        new_round = 1'b1;
        @(negedge clock);
        new_round  = 1'b0;
        model_lfsr = next_lfsr(model_lfsr);
        if (model_round != LAST_ROUND) begin
            model_round = model_round + round_t'(1);
        end
        check_round_rows();
    endtask

    initial begin
        int           fd;
        int           code;
        int           arg_a;
        int           arg_b;
        int           arg_c;
        int           arg_d;
        logic [63:0]  word;
        logic [1023:0] line_buf;

        checks      = 0;
        mismatches  = 0;
        failures    = 0;
        aborted     = 1'b0;
        reset       = 1'b1;
        pixel_valid = 1'b0;
        pixel_x     = '0;
        pixel_y     = '0;
        mouse_x     = '0;
        mouse_y     = '0;
        mouse_l     = 1'b0;
        new_round   = 1'b0;
        model_round = round_t'(1);
        model_lfsr  = '0;

        repeat (8) @(negedge clock);
        reset = 1'b0;
        check_round_rows();

        fd = $fopen("tests/geodesic_trace.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open the trace file tests/geodesic_trace.txt");
        end else begin
            while (!aborted) begin
                word = '0;
                code = $fscanf(fd, "%s", word);
                if (code != 1) begin
                    break;
                end
                if (word == "#") begin
                    code = $fgets(line_buf, fd);
                end else if (word == "mouse") begin
                    code = $fscanf(fd, "%d %d %d", arg_a, arg_b, arg_c);
                    set_mouse(coord_x_t'(arg_a), coord_y_t'(arg_b), arg_c != 0);
                end else if (word == "pixel") begin
                    code = $fscanf(fd, "%d %d %h", arg_a, arg_b, arg_c);
                    scan_pixel(coord_x_t'(arg_a), coord_y_t'(arg_b), color_t'(arg_c));
                end else if (word == "score") begin
                    code = $fscanf(fd, "%d %d %d %d", arg_a, arg_b, arg_c, arg_d);
                    check_score(count_t'(arg_a), count_t'(arg_b), count_t'(arg_c), arg_d);
                end else if (word == "round") begin
                    pulse_new_round();
                end else begin
                    failures++;
                    aborted = 1'b1;
                    $display("unknown command in the trace file");
                end
            end
            $fclose(fd);
        end

        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- geodesic_game.f
design/geodesic_pkg.sv
design/round_control.sv
design/pixel_geometry.sv
design/pixel_scorer.sv
design/geodesic_game.sv
tests/tb_clock.sv
tests/geodesic_game_properties.sv
tests/geodesic_game_tb.sv

//--- Makefile
TOP = geodesic_game_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f geodesic_game.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f geodesic_game.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir

//--- tests/geodesic_trace.txt
# mouse x y button | pixel x y color_hex | round
# score drawn overlap off verdict, verdict 0 none 1 correct 2 incorrect
mouse 120 0 0
score 0 0 0 0
pixel 0 0 0000
pixel 48 32 001F
pixel 60 32 FFFF
pixel 48 20 FFFF
pixel 31 32 001F
# cursor over the ring
mouse 60 32 0
pixel 60 32 FDA0
pixel 62 32 001F
pixel 60 30 FFFF
# trail along the arc, one rescan, then one pixel off it
mouse 31 24 1
pixel 31 24 FDA0
pixel 32 24 FDA0
pixel 31 25 FDA0
pixel 32 25 FDA0
pixel 31 24 FDA0
score 4 4 0 0
mouse 31 39 1
pixel 31 39 FDA0
pixel 32 39 FDA0
pixel 31 40 FDA0
pixel 32 40 FDA0
mouse 40 32 1
pixel 40 32 FDA0
score 9 8 1 0
# release shows the arc
mouse 120 0 0
score 9 8 1 1
pixel 31 32 F800
pixel 31 24 F800
pixel 40 32 F81E
pixel 31 40 0000
# second round on the right half
round
score 0 0 0 0
pixel 40 32 001F
mouse 40 32 1
pixel 40 32 FDA0
mouse 120 0 0
score 1 0 1 2
pixel 40 32 07E0
pixel 66 32 F800
# last round, then one pulse past it
round
score 0 0 0 0
pixel 40 32 001F
round
score 0 0 0 0
